// ==== logic/controlUnit_macros.svh ====
`ifndef CONTROL_UNIT_MACROS_SVH
`define CONTROL_UNIT_MACROS_SVH

// --------------------
// Instruction word

// Instruction register width
`define WORD_WIDTH 32

// Opcode field of the instruction register
`define OPCODE_MSB 31
`define OPCODE_LSB 27

// --------------------
// Sequencer

// Execute step counter, longest class is load with five steps
`define STEP_WIDTH 3

`endif

// ==== logic/controlUnitPkg.sv ====
`include "controlUnit_macros.svh"

package controlUnitPkg;

	// Opcode encodings, undefined codes decode as nop
	typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
		opLoad   = 5'b00000,
		opLdi    = 5'b00001,
		opStore  = 5'b00010,
		opAdd    = 5'b00011,
		opSub    = 5'b00100,
		opShr    = 5'b00101,
		opShra   = 5'b00110,
		opShl    = 5'b00111,
		opRor    = 5'b01000,
		opRol    = 5'b01001,
		opAnd    = 5'b01010,
		opOr     = 5'b01011,
		opAddi   = 5'b01100,
		opAndi   = 5'b01101,
		opOri    = 5'b01110,
		opNeg    = 5'b10001,
		opNot    = 5'b10010,
		opBranch = 5'b10011,
		opNop    = 5'b11010,
		opHalt   = 5'b11011
	} opcode_e;

	// Instruction classes, each with its own execute sequence
	typedef enum logic [3:0] {
		classLoad,
		classLoadImm,
		classStore,
		classAluReg,
		classAluImm,
		classAluUnary,
		classBranch,
		classNop,
		classHalt
	} instrClass_e;

	// ALU function select; aluBranch adds the offset to PC
	typedef enum logic [3:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShr,
		aluShra,
		aluShl,
		aluRor,
		aluRol,
		aluNeg,
		aluNot,
		aluBranch
	} aluOp_e;

	typedef enum logic [2:0] {
		phaseReset,
		phaseT0,
		phaseT1,
		phaseT2,
		phaseExec,
		phaseHalt
	} phase_e;

endpackage

// ==== logic/opcodeDecoder.sv ====
`include "controlUnit_macros.svh"

module opcodeDecoder (
	input  logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode,
	output controlUnitPkg::instrClass_e      decClass,
	output controlUnitPkg::aluOp_e           decAluOp
);

	controlUnitPkg::opcode_e op;

	assign op = controlUnitPkg::opcode_e'(opcode);

	// --------------------
	// Instruction class
	always_comb begin
		case (op)
			controlUnitPkg::opLoad:  decClass = controlUnitPkg::classLoad;
			controlUnitPkg::opLdi:   decClass = controlUnitPkg::classLoadImm;
			controlUnitPkg::opStore: decClass = controlUnitPkg::classStore;
			controlUnitPkg::opAdd, controlUnitPkg::opSub,
			controlUnitPkg::opAnd, controlUnitPkg::opOr,
			controlUnitPkg::opShr, controlUnitPkg::opShra, controlUnitPkg::opShl,
			controlUnitPkg::opRor, controlUnitPkg::opRol:
				decClass = controlUnitPkg::classAluReg;
			controlUnitPkg::opAddi, controlUnitPkg::opAndi, controlUnitPkg::opOri:
				decClass = controlUnitPkg::classAluImm;
			controlUnitPkg::opNeg, controlUnitPkg::opNot:
				decClass = controlUnitPkg::classAluUnary;
			controlUnitPkg::opBranch: decClass = controlUnitPkg::classBranch;
			controlUnitPkg::opHalt:   decClass = controlUnitPkg::classHalt;
			// nop and every undefined code
			default: decClass = controlUnitPkg::classNop;
		endcase
	end

	// --------------------
	// ALU operation
	always_comb begin
		case (op)
			// Memory classes form their address with an add
			controlUnitPkg::opLoad, controlUnitPkg::opLdi, controlUnitPkg::opStore,
			controlUnitPkg::opAdd, controlUnitPkg::opAddi:
				decAluOp = controlUnitPkg::aluAdd;
			controlUnitPkg::opSub:  decAluOp = controlUnitPkg::aluSub;
			controlUnitPkg::opAnd, controlUnitPkg::opAndi:
				decAluOp = controlUnitPkg::aluAnd;
			controlUnitPkg::opOr, controlUnitPkg::opOri:
				decAluOp = controlUnitPkg::aluOr;
			controlUnitPkg::opShr:    decAluOp = controlUnitPkg::aluShr;
			controlUnitPkg::opShra:   decAluOp = controlUnitPkg::aluShra;
			controlUnitPkg::opShl:    decAluOp = controlUnitPkg::aluShl;
			controlUnitPkg::opRor:    decAluOp = controlUnitPkg::aluRor;
			controlUnitPkg::opRol:    decAluOp = controlUnitPkg::aluRol;
			controlUnitPkg::opNeg:    decAluOp = controlUnitPkg::aluNeg;
			controlUnitPkg::opNot:    decAluOp = controlUnitPkg::aluNot;
			controlUnitPkg::opBranch: decAluOp = controlUnitPkg::aluBranch;
			default:                  decAluOp = controlUnitPkg::aluNone;
		endcase
	end

endmodule

// ==== logic/stepSequencer.sv ====
`include "controlUnit_macros.svh"

module stepSequencer (
	input  logic                        clock,
	input  logic                        reset,
	input  controlUnitPkg::instrClass_e decClass,
	input  controlUnitPkg::aluOp_e      decAluOp,
	output controlUnitPkg::phase_e      phase,
	output logic [`STEP_WIDTH-1:0]      step,
	output controlUnitPkg::instrClass_e curClass,
	output controlUnitPkg::aluOp_e      curAluOp,
	output logic                        clear,
	output logic                        run
);

	localparam logic [`STEP_WIDTH-1:0] stepOne = 'd1;

	logic [`STEP_WIDTH-1:0] lastStep;

	// Number of execute steps for each class
	function automatic logic [`STEP_WIDTH-1:0] classLength(
		input controlUnitPkg::instrClass_e cls
	);
		case (cls)
			controlUnitPkg::classLoad:     return 'd5;
			controlUnitPkg::classLoadImm:  return 'd3;
			controlUnitPkg::classStore:    return 'd4;
			controlUnitPkg::classAluReg:   return 'd3;
			controlUnitPkg::classAluImm:   return 'd3;
			controlUnitPkg::classAluUnary: return 'd2;
			controlUnitPkg::classBranch:   return 'd4;
			default:                       return 'd1;
		endcase
	endfunction

	assign lastStep = classLength(curClass) - stepOne;

	// --------------------
	// Phase and step FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			phase    <= controlUnitPkg::phaseReset;
			step     <= '0;
			curClass <= controlUnitPkg::classNop;
		end else begin
			case (phase)
				controlUnitPkg::phaseReset: phase <= controlUnitPkg::phaseT0;
				controlUnitPkg::phaseT0:    phase <= controlUnitPkg::phaseT1;
				controlUnitPkg::phaseT1:    phase <= controlUnitPkg::phaseT2;
				controlUnitPkg::phaseT2: begin
					// IR holds the new instruction during T2
					phase    <= controlUnitPkg::phaseExec;
					step     <= '0;
					curClass <= decClass;
				end
				controlUnitPkg::phaseExec: begin
					if (step == lastStep) begin
						step <= '0;
						if (curClass == controlUnitPkg::classHalt) begin
							phase <= controlUnitPkg::phaseHalt;
						end else begin
							phase <= controlUnitPkg::phaseT0;
						end
					end else begin
						step <= step + stepOne;
					end
				end
				// Halt waits for reset
				controlUnitPkg::phaseHalt: phase <= controlUnitPkg::phaseHalt;
				default: phase <= controlUnitPkg::phaseReset;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (phase == controlUnitPkg::phaseT2) begin
			curAluOp <= decAluOp;
		end
	end

	assign clear = (phase == controlUnitPkg::phaseReset);
	assign run   = (phase != controlUnitPkg::phaseHalt);

	// --------------------
	// Assertions
	stepBelowLength: assert property (@(posedge clock) disable iff (reset)
		phase == controlUnitPkg::phaseExec |-> step < classLength(curClass))
		else $error("step %0d past the length of class %s", step, curClass.name());

endmodule

// ==== logic/controlSignalGen.sv ====
`include "controlUnit_macros.svh"

module controlSignalGen (
	input  controlUnitPkg::phase_e      phase,
	input  logic [`STEP_WIDTH-1:0]      step,
	input  controlUnitPkg::instrClass_e curClass,
	input  controlUnitPkg::aluOp_e      curAluOp,
	input  logic                        conFF,
	output logic                        pcOut,
	output logic                        mdrOut,
	output logic                        zLowOut,
	output logic                        baOut,
	output logic                        cSignOut,
	output logic                        rOut,
	output logic                        rIn,
	output logic                        gra,
	output logic                        grb,
	output logic                        grc,
	output logic                        mdrIn,
	output logic                        marIn,
	output logic                        yIn,
	output logic                        irIn,
	output logic                        pcIn,
	output logic                        conIn,
	output logic                        zLowIn,
	output logic                        incPc,
	output logic                        mdRead,
	output logic                        write,
	output controlUnitPkg::aluOp_e      aluOp
);

	always_comb begin
		pcOut    = 1'b0;
		mdrOut   = 1'b0;
		zLowOut  = 1'b0;
		baOut    = 1'b0;
		cSignOut = 1'b0;
		rOut     = 1'b0;
		rIn      = 1'b0;
		gra      = 1'b0;
		grb      = 1'b0;
		grc      = 1'b0;
		mdrIn    = 1'b0;
		marIn    = 1'b0;
		yIn      = 1'b0;
		irIn     = 1'b0;
		pcIn     = 1'b0;
		conIn    = 1'b0;
		zLowIn   = 1'b0;
		incPc    = 1'b0;
		mdRead   = 1'b0;
		write    = 1'b0;
		aluOp    = controlUnitPkg::aluNone;

		case (phase)
			// --------------------
			// Fetch
			controlUnitPkg::phaseT0: begin
				pcOut  = 1'b1;
				marIn  = 1'b1;
				incPc  = 1'b1;
				zLowIn = 1'b1;
			end
			controlUnitPkg::phaseT1: begin
				zLowOut = 1'b1;
				pcIn    = 1'b1;
				mdRead  = 1'b1;
				mdrIn   = 1'b1;
			end
			controlUnitPkg::phaseT2: begin
				mdrOut = 1'b1;
				irIn   = 1'b1;
			end
			// --------------------
			// Execute
			controlUnitPkg::phaseExec: begin
				case (curClass)
					// Effective address is Rb plus the sign extended constant
					controlUnitPkg::classLoad, controlUnitPkg::classLoadImm,
					controlUnitPkg::classStore: begin
						case (step)
							0: begin
								grb   = 1'b1;
								baOut = 1'b1;
								yIn   = 1'b1;
							end
							1: begin
								cSignOut = 1'b1;
								zLowIn   = 1'b1;
								aluOp    = curAluOp;
							end
							2: begin
								zLowOut = 1'b1;
								if (curClass == controlUnitPkg::classLoadImm) begin
									gra = 1'b1;
									rIn = 1'b1;
								end else begin
									marIn = 1'b1;
								end
							end
							3: begin
								if (curClass == controlUnitPkg::classLoad) begin
									mdRead = 1'b1;
									mdrIn  = 1'b1;
								end else begin
									gra   = 1'b1;
									baOut = 1'b1;
									write = 1'b1;
								end
							end
							4: begin
								mdrOut = 1'b1;
								gra    = 1'b1;
								rIn    = 1'b1;
							end
							default: ;
						endcase
					end
					controlUnitPkg::classAluReg, controlUnitPkg::classAluImm: begin
						case (step)
							0: begin
								grb  = 1'b1;
								rOut = 1'b1;
								yIn  = 1'b1;
							end
							1: begin
								zLowIn = 1'b1;
								aluOp  = curAluOp;
								if (curClass == controlUnitPkg::classAluReg) begin
									grc  = 1'b1;
									rOut = 1'b1;
								end else begin
									cSignOut = 1'b1;
								end
							end
							2: begin
								zLowOut = 1'b1;
								gra     = 1'b1;
								rIn     = 1'b1;
							end
							default: ;
						endcase
					end
					controlUnitPkg::classAluUnary: begin
						if (step == 0) begin
							grb    = 1'b1;
							rOut   = 1'b1;
							zLowIn = 1'b1;
							aluOp  = curAluOp;
						end else begin
							zLowOut = 1'b1;
							gra     = 1'b1;
							rIn     = 1'b1;
						end
					end
					controlUnitPkg::classBranch: begin
						case (step)
							0: begin
								gra   = 1'b1;
								rOut  = 1'b1;
								conIn = 1'b1;
							end
							1: begin
								pcOut = 1'b1;
								yIn   = 1'b1;
							end
							2: begin
								cSignOut = 1'b1;
								zLowIn   = 1'b1;
								aluOp    = curAluOp;
							end
							// Target is loaded only when the condition holds
							3: begin
								zLowOut = 1'b1;
								pcIn    = conFF;
							end
							default: ;
						endcase
					end
					// nop and halt spend their step idle
					default: ;
				endcase
			end
			// Reset and halt leave every strobe low
			default: ;
		endcase

		// Only one register select drives the register file decoder
		assert ($countones({gra, grb, grc}) <= 1)
			else $error("more than one of gra, grb, grc raised");
		// The ALU result is only useful when Z captures it
		assert (zLowIn || aluOp == controlUnitPkg::aluNone)
			else $error("aluOp %s without zLowIn", aluOp.name());
	end

endmodule

// ==== logic/controlUnit.sv ====
`include "controlUnit_macros.svh"

module controlUnit (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`WORD_WIDTH-1:0] irReg,
	input  logic                   conFF,
	output logic                   pcOut,
	output logic                   mdrOut,
	output logic                   zLowOut,
	output logic                   baOut,
	output logic                   cSignOut,
	output logic                   rOut,
	output logic                   rIn,
	output logic                   gra,
	output logic                   grb,
	output logic                   grc,
	output logic                   mdrIn,
	output logic                   marIn,
	output logic                   yIn,
	output logic                   irIn,
	output logic                   pcIn,
	output logic                   conIn,
	output logic                   zLowIn,
	output logic                   incPc,
	output logic                   mdRead,
	output logic                   write,
	output controlUnitPkg::aluOp_e aluOp,
	output logic                   clear,
	output logic                   run
);

	controlUnitPkg::instrClass_e decClass;
	controlUnitPkg::aluOp_e      decAluOp;
	controlUnitPkg::phase_e      phase;
	logic [`STEP_WIDTH-1:0]      step;
	controlUnitPkg::instrClass_e curClass;
	controlUnitPkg::aluOp_e      curAluOp;

	opcodeDecoder uDecoder (
		.opcode   (irReg[`OPCODE_MSB:`OPCODE_LSB]),
		.decClass (decClass),
		.decAluOp (decAluOp)
	);

	// Phase, step and latched instruction
	stepSequencer uSequencer (.*);

	// Datapath strobes for the current step
	controlSignalGen uSignalGen (.*);

endmodule

// ==== sim/controlUnitChecks.sv ====
`include "controlUnit_macros.svh"

module controlUnitChecks (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [19:0]            strobes,
	input  controlUnitPkg::aluOp_e aluOp,
	input  logic                   clear,
	input  logic                   run,
	input  logic                   conFF,
	input  controlUnitPkg::phase_e expPhase,
	input  logic [`STEP_WIDTH-1:0] expStep,
	input  logic [`STEP_WIDTH-1:0] expLen,
	input  logic [`STEP_WIDTH-1:0] expZStep,
	input  controlUnitPkg::aluOp_e expAluOp,
	input  logic                   expCSign,
	input  logic                   expBranch,
	output int                     valueErrors,
	output int                     lengthErrors
);
	timeunit 1ns;
	timeprecision 100ps;

	// Positions in the strobe vector built by the testbench
	localparam int bitPcOut = 19, bitMdrOut = 18, bitZLowOut = 17, bitCSignOut = 15;
	localparam int bitMdrIn = 9, bitMarIn = 8, bitIrIn = 6, bitPcIn = 5;
	localparam int bitZLowIn = 3, bitIncPc = 2, bitMdRead = 1;

	logic [7:0]             gapCount;
	controlUnitPkg::aluOp_e wantAlu;

	// Strobes of the three fetch steps
	function automatic logic [19:0] fetchPattern(input controlUnitPkg::phase_e ph);
		logic [19:0] v;
		v = '0;
		case (ph)
			controlUnitPkg::phaseT0: begin
				v[bitPcOut]  = 1'b1;
				v[bitMarIn]  = 1'b1;
				v[bitIncPc]  = 1'b1;
				v[bitZLowIn] = 1'b1;
			end
			controlUnitPkg::phaseT1: begin
				v[bitZLowOut] = 1'b1;
				v[bitPcIn]    = 1'b1;
				v[bitMdRead]  = 1'b1;
				v[bitMdrIn]   = 1'b1;
			end
			controlUnitPkg::phaseT2: begin
				v[bitMdrOut] = 1'b1;
				v[bitIrIn]   = 1'b1;
			end
			default: ;
		endcase
		return v;
	endfunction

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		valueErrors++;
		$display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
	endtask

	// ALU select only in the step that loads Z
	always_comb begin
		if (expPhase == controlUnitPkg::phaseExec && expStep == expZStep) begin
			wantAlu = expAluOp;
		end else begin
			wantAlu = controlUnitPkg::aluNone;
		end
	end

	// Cycles since the last incPc, zero until the first one after reset
	always @(posedge clock) begin
		if (reset) begin
			gapCount <= '0;
		end else if (strobes[bitIncPc]) begin
			gapCount <= 8'd1;
		end else if (gapCount != '0) begin
			gapCount <= gapCount + 8'd1;
		end
	end

	// --------------------
	// Reset, halt and fetch
	clearLevel: assert property (@(posedge clock) disable iff (reset)
		clear == (expPhase == controlUnitPkg::phaseReset))
		else reportValue("clear", 32'($sampled(expPhase) == controlUnitPkg::phaseReset),
			32'($sampled(clear)));

	runLevel: assert property (@(posedge clock) disable iff (reset)
		run == (expPhase != controlUnitPkg::phaseHalt))
		else reportValue("run", 32'($sampled(expPhase) != controlUnitPkg::phaseHalt),
			32'($sampled(run)));

	idleStrobes: assert property (@(posedge clock) disable iff (reset)
		expPhase inside {controlUnitPkg::phaseReset, controlUnitPkg::phaseHalt}
			|-> strobes == '0)
		else reportValue("strobes", 32'h0, 32'($sampled(strobes)));

	fetchStrobes: assert property (@(posedge clock) disable iff (reset)
		expPhase inside {controlUnitPkg::phaseT0, controlUnitPkg::phaseT1, controlUnitPkg::phaseT2}
			|-> strobes == fetchPattern(expPhase))
		else reportValue("strobes", 32'(fetchPattern($sampled(expPhase))),
			32'($sampled(strobes)));

	incPcOnlyT0: assert property (@(posedge clock) disable iff (reset)
		strobes[bitIncPc] == (expPhase == controlUnitPkg::phaseT0))
		else reportValue("incPc", 32'($sampled(expPhase) == controlUnitPkg::phaseT0),
			32'($sampled(strobes[bitIncPc])));

	// --------------------
	// Execute steps
	zLowStep: assert property (@(posedge clock) disable iff (reset)
		expPhase == controlUnitPkg::phaseExec |-> strobes[bitZLowIn] == (expStep == expZStep))
		else reportValue("zLowIn", 32'($sampled(expStep) == $sampled(expZStep)),
			32'($sampled(strobes[bitZLowIn])));

	aluSelect: assert property (@(posedge clock) disable iff (reset)
		aluOp == wantAlu)
		else reportValue("aluOp", 32'($sampled(wantAlu)), 32'($sampled(aluOp)));

	constantSign: assert property (@(posedge clock) disable iff (reset)
		(expPhase == controlUnitPkg::phaseExec && expStep == expZStep)
			|-> strobes[bitCSignOut] == expCSign)
		else reportValue("cSignOut", 32'($sampled(expCSign)),
			32'($sampled(strobes[bitCSignOut])));

	// PC is loaded in the fourth branch step, and then only on a true condition
	branchTarget: assert property (@(posedge clock) disable iff (reset)
		expPhase == controlUnitPkg::phaseExec
			|-> strobes[bitPcIn] == (expBranch && expStep == 3 && conFF))
		else reportValue("pcIn", 32'($sampled(expBranch) && $sampled(expStep) == 3
			&& $sampled(conFF)), 32'($sampled(strobes[bitPcIn])));

	instrLength: assert property (@(posedge clock) disable iff (reset)
		(strobes[bitIncPc] && gapCount != '0) |-> gapCount == 8'(expLen) + 8'd3)
		else begin
			lengthErrors++;
			$display("Instruction took %0d cycles between incPc pulses, expected %0d, at %0t",
				$sampled(gapCount), $sampled(expLen) + 3, $time);
		end

endmodule

// ==== sim/controlUnitTb.sv ====
`include "controlUnit_macros.svh"

module controlUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int numInstr      = 300;
	localparam int tailInstr     = 4;
	localparam int longestInstr  = 8;
	localparam int resetCycles   = 8;
	localparam int haltCycles    = 10;
	localparam int timeoutCycles = (numInstr + tailInstr) * longestInstr + 100;
	localparam int opWidth       = `OPCODE_MSB - `OPCODE_LSB + 1;

	typedef logic [`STEP_WIDTH-1:0] stepCount_t;

	logic clock, reset, conFF;
	logic [`WORD_WIDTH-1:0] irReg;
	logic pcOut, mdrOut, zLowOut, baOut, cSignOut, rOut, rIn, gra, grb, grc;
	logic mdrIn, marIn, yIn, irIn, pcIn, conIn, zLowIn, incPc, mdRead, write;
	logic clear, run;
	controlUnitPkg::aluOp_e aluOp;
	logic [19:0] strobes;

	// Reference model state
	controlUnitPkg::phase_e expPhase = controlUnitPkg::phaseReset;
	stepCount_t             expStep  = '0;
	logic [opWidth-1:0]     expCode  = controlUnitPkg::opNop;
	stepCount_t             expLen, expZStep;
	controlUnitPkg::aluOp_e expAluOp;
	logic                   expCSign, expBranch;

	int          valueErrors, lengthErrors;
	int          cycleCount = 0;
	logic [31:0] seed = 32'h50dfb069;

	controlUnit u_dut (.*);

	controlUnitChecks u_checks (.*);

	assign strobes = {pcOut, mdrOut, zLowOut, baOut, cSignOut, rOut, rIn, gra, grb, grc,
		mdrIn, marIn, yIn, irIn, pcIn, conIn, zLowIn, incPc, mdRead, write};

	// --------------------
	// Instruction set tables
	function automatic stepCount_t execLength(input logic [opWidth-1:0] code);
		case (code)
			controlUnitPkg::opLoad:   return stepCount_t'(5);
			controlUnitPkg::opStore:  return stepCount_t'(4);
			controlUnitPkg::opBranch: return stepCount_t'(4);
			controlUnitPkg::opLdi, controlUnitPkg::opAdd, controlUnitPkg::opSub,
			controlUnitPkg::opShr, controlUnitPkg::opShra, controlUnitPkg::opShl,
			controlUnitPkg::opRor, controlUnitPkg::opRol, controlUnitPkg::opAnd,
			controlUnitPkg::opOr, controlUnitPkg::opAddi, controlUnitPkg::opAndi,
			controlUnitPkg::opOri:    return stepCount_t'(3);
			controlUnitPkg::opNeg, controlUnitPkg::opNot: return stepCount_t'(2);
			default:                  return stepCount_t'(1);
		endcase
	endfunction

	// Step that loads Z, seven when the class has none
	function automatic stepCount_t zStepOf(input logic [opWidth-1:0] code);
		case (execLength(code))
			stepCount_t'(1): return stepCount_t'(7);
			stepCount_t'(2): return stepCount_t'(0);
			default:         return (code == controlUnitPkg::opBranch) ? stepCount_t'(2)
				: stepCount_t'(1);
		endcase
	endfunction

	function automatic controlUnitPkg::aluOp_e aluOf(input logic [opWidth-1:0] code);
		case (code)
			controlUnitPkg::opSub:    return controlUnitPkg::aluSub;
			controlUnitPkg::opShr:    return controlUnitPkg::aluShr;
			controlUnitPkg::opShra:   return controlUnitPkg::aluShra;
			controlUnitPkg::opShl:    return controlUnitPkg::aluShl;
			controlUnitPkg::opRor:    return controlUnitPkg::aluRor;
			controlUnitPkg::opRol:    return controlUnitPkg::aluRol;
			controlUnitPkg::opAnd, controlUnitPkg::opAndi: return controlUnitPkg::aluAnd;
			controlUnitPkg::opOr, controlUnitPkg::opOri:   return controlUnitPkg::aluOr;
			controlUnitPkg::opNeg:    return controlUnitPkg::aluNeg;
			controlUnitPkg::opNot:    return controlUnitPkg::aluNot;
			controlUnitPkg::opBranch: return controlUnitPkg::aluBranch;
			// Address arithmetic of the memory classes is an add too
			controlUnitPkg::opLoad, controlUnitPkg::opLdi, controlUnitPkg::opStore,
			controlUnitPkg::opAdd, controlUnitPkg::opAddi: return controlUnitPkg::aluAdd;
			default:                  return controlUnitPkg::aluNone;
		endcase
	endfunction

	assign expLen    = execLength(expCode);
	assign expZStep  = zStepOf(expCode);
	assign expAluOp  = aluOf(expCode);
	assign expBranch = (expCode == controlUnitPkg::opBranch);
	assign expCSign  = expCode inside {controlUnitPkg::opLoad, controlUnitPkg::opLdi,
		controlUnitPkg::opStore, controlUnitPkg::opAddi, controlUnitPkg::opAndi,
		controlUnitPkg::opOri, controlUnitPkg::opBranch};

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// --------------------
	// Expected phase, one control step per clock
	always @(posedge clock) begin
		if (reset) begin
			expPhase <= controlUnitPkg::phaseReset;
			expStep  <= '0;
		end else begin
			case (expPhase)
				controlUnitPkg::phaseReset: expPhase <= controlUnitPkg::phaseT0;
				controlUnitPkg::phaseT0:    expPhase <= controlUnitPkg::phaseT1;
				controlUnitPkg::phaseT1:    expPhase <= controlUnitPkg::phaseT2;
				controlUnitPkg::phaseT2: begin
					expPhase <= controlUnitPkg::phaseExec;
					expStep  <= '0;
					expCode  <= irReg[`OPCODE_MSB:`OPCODE_LSB];
				end
				controlUnitPkg::phaseExec: begin
					if (expStep + stepCount_t'(1) != expLen) begin
						expStep <= expStep + stepCount_t'(1);
					end else if (expCode == controlUnitPkg::opHalt) begin
						expPhase <= controlUnitPkg::phaseHalt;
					end else begin
						expPhase <= controlUnitPkg::phaseT0;
					end
				end
				default: ;
			endcase
		end
	end

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: instruction stream still running after %0d cycles", cycleCount);
			$display("Test failures found");
			$finish;
		end
	end

	// --------------------
	// Stimulus
	task automatic randomizeCondition();
		seed  = lcgNext(seed);
		conFF = seed[31];
	endtask

	// Random opcode over all 32 codes; halt only where asked for
	task automatic driveInstruction(input logic makeHalt);
		logic [opWidth-1:0] code;
		seed = lcgNext(seed);
		code = seed[31:32-opWidth];
		if (makeHalt) begin
			code = controlUnitPkg::opHalt;
		end else if (code == controlUnitPkg::opHalt) begin
			code = controlUnitPkg::opNop;
		end
		irReg = seed;
		irReg[`OPCODE_MSB:`OPCODE_LSB] = code;
	endtask

	// New instruction during T1 so it is steady through T2
	task automatic sendInstructions(input int count, input logic endWithHalt);
		int sent;
		sent = 0;
		while (sent < count) begin
			@(negedge clock);
			randomizeCondition();
			if (expPhase == controlUnitPkg::phaseT1) begin
				driveInstruction(endWithHalt && sent == count - 1);
				sent++;
			end
		end
		do begin
			@(negedge clock);
			randomizeCondition();
		end while (expPhase != controlUnitPkg::phaseT0 && expPhase != controlUnitPkg::phaseHalt);
	endtask

	initial begin
		reset = 1'b1;
		irReg = '0;
		conFF = 1'b0;
		repeat (resetCycles) @(negedge clock);
		reset = 1'b0;
		sendInstructions(numInstr, 1'b1);
		// Sit in halt for a while
		repeat (haltCycles) @(negedge clock);
		reset = 1'b1;
		repeat (resetCycles) @(negedge clock);
		reset = 1'b0;
		sendInstructions(tailInstr, 1'b0);
		@(negedge clock);
		$display("Errors: %0d value, %0d length, in %0d cycles", valueErrors, lengthErrors,
			cycleCount);
		if (valueErrors == 0 && lengthErrors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/controlUnitPkg.sv
logic/opcodeDecoder.sv
logic/stepSequencer.sv
logic/controlSignalGen.sv
logic/controlUnit.sv
sim/controlUnitChecks.sv
sim/controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)

.PHONY: sim clean
